// File: logic/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    // ----------------------------------------
    // controller steps.
    // ----------------------------------------
    typedef enum logic [2:0] {
        idle,
        lookup,
        evict,
        fill,
        merge,
        respond
    } cache_state_e;

    // host request kind.
    typedef enum logic {
        op_read,
        op_write
    } req_op_e;

endpackage

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int num_sets   = 4,
    parameter int num_ways   = 4,
    parameter int line_words = 16,
    localparam int set_w  = $clog2(num_sets),
    localparam int way_w  = $clog2(num_ways),
    localparam int word_w = $clog2(line_words),
    localparam int byte_w = $clog2(dcache_pkg::strb_w),
    localparam int tag_w  = dcache_pkg::addr_w - set_w - word_w - byte_w
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [dcache_pkg::addr_w-1:0] s_addr,
    input  logic                          s_arvalid,
    input  logic                          s_awvalid,
    input  logic [dcache_pkg::data_w-1:0] s_wdata,
    input  logic [dcache_pkg::strb_w-1:0] s_wstrb,
    input  logic                          hit,
    input  logic [way_w-1:0]              hit_way,
    input  logic [way_w-1:0]              victim_way,
    input  logic                          victim_dirty,
    input  logic [tag_w-1:0]              victim_tag,
    input  logic                          evict_done,
    input  logic                          fill_done,
    input  logic [dcache_pkg::data_w-1:0] rd_word,
    output logic [dcache_pkg::data_w-1:0] s_rdata,
    output logic                          s_rvalid,
    output logic                          s_wready,
    output logic [tag_w-1:0]              req_tag,
    output logic [set_w-1:0]              req_set,
    output logic [word_w-1:0]             req_word,
    output logic                          evict_start,
    output logic                          fill_start,
    output logic [dcache_pkg::addr_w-1:0] line_addr,
    output logic                          tag_update,
    output logic [way_w-1:0]              way_sel,
    output dcache_pkg::req_op_e           op,
    output logic                          wr_en,
    output logic [dcache_pkg::strb_w-1:0] wr_strb,
    output logic [dcache_pkg::data_w-1:0] wr_data
);

    import dcache_pkg::*;

    cache_state_e state;
    req_op_e      req_op;
    logic         accept;

    // read wins when both valids are up.
    assign accept = (state == idle) && (s_arvalid || s_awvalid);

    // ----------------------------------------
    // request sequencing.
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= idle;
            req_op      <= op_read;
            evict_start <= 1'b0;
            fill_start  <= 1'b0;
        end else begin
            evict_start <= 1'b0;
            fill_start  <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        state  <= lookup;
                        req_op <= s_arvalid ? op_read : op_write;
                    end
                end
                lookup: begin
                    if (hit) begin
                        state <= (req_op == op_write) ? merge : respond;
                    end else if (victim_dirty) begin
                        state       <= evict;
                        evict_start <= 1'b1;
                    end else begin
                        state      <= fill;
                        fill_start <= 1'b1;
                    end
                end
                evict: begin
                    if (evict_done) begin
                        state      <= fill;
                        fill_start <= 1'b1;
                    end
                end
                // back to lookup, which now hits.
                fill: begin
                    if (fill_done) begin
                        state <= lookup;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag  <= s_addr[addr_w-1 -: tag_w];
            req_set  <= s_addr[byte_w + word_w +: set_w];
            req_word <= s_addr[byte_w +: word_w];
            wr_data  <= s_wdata;
            wr_strb  <= s_wstrb;
        end
        if (state == lookup && hit) begin
            s_rdata <= rd_word;
        end
    end

    // write commits on the same edge that samples s_wready.
    assign s_rvalid = (state == respond);
    assign s_wready = (state == merge);
    assign wr_en    = (state == merge);
    assign op       = (state == merge) ? op_write : op_read;

    assign way_sel    = (state == evict || state == fill) ? victim_way : hit_way;
    assign tag_update = (state == fill) && fill_done;

    // victim address while evicting, request address otherwise.
    assign line_addr = {(state == evict) ? victim_tag : req_tag, req_set,
                        {(word_w + byte_w){1'b0}}};

endmodule

// File: logic/tag_store.sv
`timescale 1ns/1ps

module tag_store #(
    parameter int num_sets   = 4,
    parameter int num_ways   = 4,
    parameter int line_words = 16,
    localparam int set_w = $clog2(num_sets),
    localparam int way_w = $clog2(num_ways),
    localparam int tag_w = dcache_pkg::addr_w - set_w - $clog2(line_words)
                           - $clog2(dcache_pkg::strb_w)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [tag_w-1:0]    req_tag,
    input  logic [set_w-1:0]    req_set,
    input  logic                tag_update,
    input  logic [way_w-1:0]    way_sel,
    input  dcache_pkg::req_op_e op,
    output logic                hit,
    output logic [way_w-1:0]    hit_way,
    output logic [way_w-1:0]    victim_way,
    output logic                victim_dirty,
    output logic [tag_w-1:0]    victim_tag
);

    import dcache_pkg::*;

    logic [tag_w-1:0]    tags  [num_sets][num_ways];
    logic [num_ways-1:0] valid [num_sets];
    logic [num_ways-1:0] dirty [num_sets];
    logic [way_w-1:0]    ptr   [num_sets];

    // ----------------------------------------
    // lookup.
    // ----------------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid[req_set][w] && tags[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = w[way_w-1:0];
            end
        end
    end

    // fifo order, oldest fill goes first.
    assign victim_way   = ptr[req_set];
    assign victim_dirty = valid[req_set][victim_way] && dirty[req_set][victim_way];
    assign victim_tag   = tags[req_set][victim_way];

    // ----------------------------------------
    // updates.
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                ptr[s]   <= '0;
            end
        end else if (tag_update) begin
            valid[req_set][way_sel] <= 1'b1;
            dirty[req_set][way_sel] <= 1'b0;
            ptr[req_set]            <= ptr[req_set] + 1'b1;
        end else if (op == op_write && hit) begin
            dirty[req_set][way_sel] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_update) begin
            tags[req_set][way_sel] <= req_tag;
        end
    end

endmodule

// File: logic/line_store.sv
`timescale 1ns/1ps

module line_store #(
    parameter int num_sets   = 4,
    parameter int num_ways   = 4,
    parameter int line_words = 16,
    localparam int set_w  = $clog2(num_sets),
    localparam int way_w  = $clog2(num_ways),
    localparam int word_w = $clog2(line_words)
) (
    input  logic                          clk,
    input  logic [set_w-1:0]              req_set,
    input  logic [way_w-1:0]              way_sel,
    input  logic [word_w-1:0]             req_word,
    input  logic                          wr_en,
    input  logic [dcache_pkg::strb_w-1:0] wr_strb,
    input  logic [dcache_pkg::data_w-1:0] wr_data,
    input  logic                          fill_we,
    input  logic [word_w-1:0]             fill_idx,
    input  logic [dcache_pkg::data_w-1:0] fill_data,
    input  logic [word_w-1:0]             evict_idx,
    output logic [dcache_pkg::data_w-1:0] rd_word,
    output logic [dcache_pkg::data_w-1:0] evict_word
);

    import dcache_pkg::*;

    logic [data_w-1:0] mem [num_sets][num_ways][line_words];

    assign rd_word    = mem[req_set][way_sel][req_word];
    assign evict_word = mem[req_set][way_sel][evict_idx];

    // fill writes whole words, host writes by byte lane.
    always_ff @(posedge clk) begin
        if (fill_we) begin
            mem[req_set][way_sel][fill_idx] <= fill_data;
        end else if (wr_en) begin
            for (int b = 0; b < strb_w; b++) begin
                if (wr_strb[b]) begin
                    mem[req_set][way_sel][req_word][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: logic/bus_master.sv
`timescale 1ns/1ps

module bus_master #(
    parameter int line_words = 16,
    localparam int word_w = $clog2(line_words)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          evict_start,
    input  logic                          fill_start,
    input  logic [dcache_pkg::addr_w-1:0] line_addr,
    input  logic [dcache_pkg::data_w-1:0] evict_word,
    output logic [word_w-1:0]             evict_idx,
    output logic                          fill_we,
    output logic [word_w-1:0]             fill_idx,
    output logic [dcache_pkg::data_w-1:0] fill_data,
    output logic                          evict_done,
    output logic                          fill_done,
    output logic [dcache_pkg::addr_w-1:0] m_araddr,
    output logic                          m_arvalid,
    input  logic                          m_arready,
    input  logic [dcache_pkg::data_w-1:0] m_rdata,
    input  logic                          m_rlast,
    input  logic                          m_rvalid,
    output logic                          m_rready,
    output logic [dcache_pkg::addr_w-1:0] m_awaddr,
    output logic                          m_awvalid,
    input  logic                          m_awready,
    output logic [dcache_pkg::data_w-1:0] m_wdata,
    output logic [dcache_pkg::strb_w-1:0] m_wstrb,
    output logic                          m_wlast,
    output logic                          m_wvalid,
    input  logic                          m_wready,
    input  logic                          m_bvalid,
    output logic                          m_bready
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        bm_idle,
        bm_ar,
        bm_rd,
        bm_aw,
        bm_wr,
        bm_b
    } bm_state_e;

    bm_state_e         state;
    logic [word_w-1:0] beat;
    logic [addr_w-1:0] burst_addr;

    // ----------------------------------------
    // one burst at a time.
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bm_idle;
            beat  <= '0;
        end else begin
            case (state)
                bm_idle: begin
                    beat <= '0;
                    if (evict_start) begin
                        state <= bm_aw;
                    end else if (fill_start) begin
                        state <= bm_ar;
                    end
                end
                bm_ar: if (m_arready) state <= bm_rd;
                bm_rd: begin
                    if (m_rvalid) begin
                        beat <= beat + 1'b1;
                        if (m_rlast) state <= bm_idle;
                    end
                end
                bm_aw: if (m_awready) state <= bm_wr;
                bm_wr: begin
                    if (m_wready) begin
                        beat <= beat + 1'b1;
                        if (m_wlast) state <= bm_b;
                    end
                end
                bm_b: if (m_bvalid) state <= bm_idle;
                default: state <= bm_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bm_idle && (evict_start || fill_start)) begin
            burst_addr <= line_addr;
        end
    end

    assign m_araddr  = burst_addr;
    assign m_arvalid = (state == bm_ar);
    assign m_rready  = (state == bm_rd);
    assign m_awaddr  = burst_addr;
    assign m_awvalid = (state == bm_aw);

    // data follows the beat index, so it holds while wready is low.
    assign m_wvalid  = (state == bm_wr);
    assign m_wdata   = evict_word;
    assign m_wstrb   = '1;
    assign m_wlast   = m_wvalid && (beat == word_w'(line_words - 1));
    assign m_bready  = (state == bm_b);

    assign evict_idx  = beat;
    assign fill_idx   = beat;
    assign fill_data  = m_rdata;
    assign fill_we    = m_rready && m_rvalid;
    assign fill_done  = fill_we && m_rlast;
    assign evict_done = m_bready && m_bvalid;

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int num_sets   = 4,
    parameter int num_ways   = 4,
    parameter int line_words = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // host port.
    input  logic [dcache_pkg::addr_w-1:0] s_addr,
    input  logic                          s_arvalid,
    input  logic                          s_awvalid,
    input  logic [dcache_pkg::data_w-1:0] s_wdata,
    input  logic [dcache_pkg::strb_w-1:0] s_wstrb,
    output logic [dcache_pkg::data_w-1:0] s_rdata,
    output logic                          s_rvalid,
    output logic                          s_wready,

    // memory bus.
    output logic [dcache_pkg::addr_w-1:0] m_araddr,
    output logic                          m_arvalid,
    input  logic                          m_arready,
    input  logic [dcache_pkg::data_w-1:0] m_rdata,
    input  logic                          m_rlast,
    input  logic                          m_rvalid,
    output logic                          m_rready,
    output logic [dcache_pkg::addr_w-1:0] m_awaddr,
    output logic                          m_awvalid,
    input  logic                          m_awready,
    output logic [dcache_pkg::data_w-1:0] m_wdata,
    output logic [dcache_pkg::strb_w-1:0] m_wstrb,
    output logic                          m_wlast,
    output logic                          m_wvalid,
    input  logic                          m_wready,
    input  logic                          m_bvalid,
    output logic                          m_bready
);

    import dcache_pkg::*;

    localparam int set_w  = $clog2(num_sets);
    localparam int way_w  = $clog2(num_ways);
    localparam int word_w = $clog2(line_words);
    localparam int tag_w  = addr_w - set_w - word_w - $clog2(strb_w);

    // ----------------------------------------
    // lookup and request fields.
    // ----------------------------------------
    logic [tag_w-1:0]  req_tag;
    logic [set_w-1:0]  req_set;
    logic [word_w-1:0] req_word;
    logic              hit;
    logic [way_w-1:0]  hit_way;
    logic [way_w-1:0]  victim_way;
    logic              victim_dirty;
    logic [tag_w-1:0]  victim_tag;
    logic              tag_update;
    logic [way_w-1:0]  way_sel;
    req_op_e           op;

    // host write into the line.
    logic              wr_en;
    logic [strb_w-1:0] wr_strb;
    logic [data_w-1:0] wr_data;
    logic [data_w-1:0] rd_word;

    // ----------------------------------------
    // burst sequencing.
    // ----------------------------------------
    logic              evict_start;
    logic              fill_start;
    logic              evict_done;
    logic              fill_done;
    logic [addr_w-1:0] line_addr;
    logic [word_w-1:0] evict_idx;
    logic [data_w-1:0] evict_word;
    logic              fill_we;
    logic [word_w-1:0] fill_idx;
    logic [data_w-1:0] fill_data;

    dcache_ctrl #(
        .num_sets   (num_sets),
        .num_ways   (num_ways),
        .line_words (line_words)
    ) u_ctrl (.*);

    tag_store #(
        .num_sets   (num_sets),
        .num_ways   (num_ways),
        .line_words (line_words)
    ) u_tags (.*);

    line_store #(
        .num_sets   (num_sets),
        .num_ways   (num_ways),
        .line_words (line_words)
    ) u_lines (.*);

    bus_master #(
        .line_words (line_words)
    ) u_bus (.*);

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int line_words = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] m_araddr,
    input  logic        m_arvalid,
    output logic        m_arready,
    output logic [31:0] m_rdata,
    output logic        m_rlast,
    output logic        m_rvalid,
    input  logic        m_rready,
    input  logic [31:0] m_awaddr,
    input  logic        m_awvalid,
    output logic        m_awready,
    input  logic [31:0] m_wdata,
    input  logic        m_wlast,
    input  logic        m_wvalid,
    output logic        m_wready,
    output logic        m_bvalid,
    input  logic        m_bready,
    output int          bursts,
    output int          beats
);

    // written-back words by word index.
    logic [31:0] store [int unsigned];
    logic [31:0] seed = 32'd41937;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function logic [31:0] word_at(input logic [31:0] addr);
        if (store.exists(addr[31:2])) begin
            return store[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    // ----------------------------------------
    // sample mid-cycle, answer after the edge.
    // ----------------------------------------
    always begin : bus_slave
        logic        ar_hs, r_hs, aw_hs, w_hs, b_hs, wlast_s;
        logic [31:0] araddr_s, awaddr_s, wdata_s;
        logic        rd_busy, wr_busy, b_pend;
        logic [31:0] rd_addr, wr_addr;
        int          rd_beat, wr_beat;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        b_pend  = 1'b0;
        rd_beat = 0;
        wr_beat = 0;
        rd_addr = '0;
        wr_addr = '0;
        bursts  = 0;
        beats   = 0;
        {m_arready, m_rvalid, m_rlast, m_awready, m_wready, m_bvalid} = '0;
        m_rdata = '0;
        forever begin
            @(negedge clk);
            ar_hs    = m_arvalid && m_arready;
            r_hs     = m_rvalid && m_rready;
            aw_hs    = m_awvalid && m_awready;
            w_hs     = m_wvalid && m_wready;
            b_hs     = m_bvalid && m_bready;
            wlast_s  = m_wlast;
            araddr_s = m_araddr;
            awaddr_s = m_awaddr;
            wdata_s  = m_wdata;
            @(posedge clk);
            #2;
            if (rst_n) begin
                if (ar_hs) begin
                    rd_busy = 1'b1;
                    rd_addr = araddr_s;
                    rd_beat = 0;
                end
                if (r_hs) begin
                    if (rd_beat == line_words - 1) rd_busy = 1'b0;
                    rd_beat++;
                end
                if (aw_hs) begin
                    wr_busy = 1'b1;
                    wr_addr = awaddr_s;
                    wr_beat = 0;
                end
                if (w_hs) begin
                    store[wr_addr[31:2] + wr_beat] = wdata_s;
                    wr_beat++;
                    beats++;
                    if (wlast_s) begin
                        wr_busy = 1'b0;
                        b_pend  = 1'b1;
                        bursts++;
                    end
                end
                if (b_hs) b_pend = 1'b0;
            end
            seed      = lcg_next(seed);
            m_arready = rst_n && !rd_busy && (seed[17:16] != 2'b00);
            m_rvalid  = rst_n && rd_busy && (seed[19:18] != 2'b00);
            m_rdata   = word_at(rd_addr + 32'(rd_beat * 4));
            m_rlast   = rd_busy && (rd_beat == line_words - 1);
            m_awready = rst_n && !wr_busy && !b_pend && (seed[21:20] != 2'b00);
            m_wready  = rst_n && wr_busy && (seed[23:22] != 2'b00);
            m_bvalid  = rst_n && b_pend;
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int max_lines = 64;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] s_addr, s_wdata, s_rdata;
    logic [3:0]  s_wstrb;
    logic        s_arvalid, s_awvalid, s_rvalid, s_wready;
    logic [31:0] m_araddr, m_rdata, m_awaddr, m_wdata;
    logic        m_arvalid, m_arready, m_rlast, m_rvalid, m_rready;
    logic        m_awvalid, m_awready, m_wlast, m_wvalid, m_wready;
    logic        m_bvalid, m_bready;
    logic [3:0]  m_wstrb;
    int          bursts, beats;

    // op, address, write data, strobe, expected.
    logic [31:0] trace [5*max_lines];
    int          n_lines;
    int          cycles = 0;
    int          limit = 0;
    int          data_errs = 0;
    int          proto_errs = 0;

    always #20 clk = ~clk;

    dcache_top uut (.*);

    mem_model mem (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: no response within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // write beats carry whole words.
    always @(negedge clk) begin
        if (m_wvalid) begin
            assert (m_wstrb == 4'hf) else begin
                $display("ERR %0t m_wstrb got %h exp %h", $time, m_wstrb, 4'hf);
                data_errs++;
            end
        end
    end

    task automatic check_quiet();
        assert (!(s_rvalid || s_wready || m_arvalid || m_awvalid || m_wvalid))
        else begin
            $display("at %0t a valid output is high before any request", $time);
            proto_errs++;
        end
    endtask

    // ----------------------------------------
    // one host request held until its pulse.
    // ----------------------------------------
    task automatic run_request(input int i);
        logic [31:0] op, exp;
        int          edges;
        logic        ar_seen, done;
        op        = trace[5*i];
        exp       = trace[5*i+4];
        s_addr    = trace[5*i+1];
        s_wdata   = trace[5*i+2];
        s_wstrb   = trace[5*i+3][3:0];
        s_arvalid = (op == 0 || op == 2);
        s_awvalid = (op == 1 || op == 3);
        edges     = 0;
        ar_seen   = 1'b0;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (m_arvalid) ar_seen = 1'b1;
            done = s_rvalid || s_wready;
        end
        if (s_arvalid) begin
            assert (s_rvalid) else begin
                $display("line %0d: read answered by a write response", i);
                proto_errs++;
            end
            assert (s_rdata == exp) else begin
                $display("ERR %0t s_rdata got %h exp %h (line %0d)", $time, s_rdata, exp, i);
                data_errs++;
            end
        end else begin
            assert (s_wready) else begin
                $display("line %0d: write answered by a read response", i);
                proto_errs++;
            end
        end
        if (op == 2 || op == 3) begin
            assert (edges == 2 && !ar_seen) else begin
                $display("line %0d: expected a hit, took %0d edges", i, edges);
                proto_errs++;
            end
        end
    endtask

    task automatic check_bursts(input int i);
        assert (bursts == int'(trace[5*i+4])) else begin
            $display("ERR %0t bursts got %0d exp %0d", $time, bursts, trace[5*i+4]);
            data_errs++;
        end
        assert (beats == int'(trace[5*i+2])) else begin
            $display("ERR %0t beats got %0d exp %0d", $time, beats, trace[5*i+2]);
            data_errs++;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        s_addr    = '0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_arvalid = 1'b0;
        s_awvalid = 1'b0;
        for (int k = 0; k < 5*max_lines; k++) trace[k] = 32'hffff_ffff;
        $readmemh("tests/dcache_trace.txt", trace);
        n_lines = 0;
        while (n_lines < max_lines && trace[5*n_lines] != 32'hffff_ffff) n_lines++;
        limit = 16 + 8 + 60 * n_lines;

        repeat (16) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        #2;
        for (int i = 0; i < n_lines; i++) begin
            if (trace[5*i] == 4) begin
                check_bursts(i);
            end else begin
                run_request(i);
                @(posedge clk);
                #2;
            end
        end
        s_arvalid = 1'b0;
        s_awvalid = 1'b0;
        repeat (2) @(posedge clk);

        $display("errors: %0d data, %0d protocol", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/dcache_trace.txt
// op addr wdata strb expected, all hex.
// op 0 read, 1 write, 2 read hit, 3 write hit, 4 check (wdata beats, expected bursts).
0 00001004 00000000 0 5a5a1004
2 00001008 00000000 0 5a5a1008
3 00001008 a1b2c3d4 5 00000000
2 00001008 00000000 0 5ab210d4
1 00002010 11223344 c 00000000
2 00002010 00000000 0 11222010
2 00002014 00000000 0 5a5a2014
0 00003000 00000000 0 5a5a3000
0 00004000 00000000 0 5a5a4000
4 00000000 00000000 0 00000000
0 00005000 00000000 0 5a5a5000
4 00000000 00000010 0 00000001
0 00001008 00000000 0 5ab210d4
2 00001004 00000000 0 5a5a1004
4 00000000 00000020 0 00000002
0 00002010 00000000 0 11222010
0 00001044 00000000 0 5a5a1044
3 00001044 ffffffff f 00000000
2 00001044 00000000 0 ffffffff
2 00001040 00000000 0 5a5a1040
0 000010c0 00000000 0 5a5a10c0
2 000010fc 00000000 0 5a5a10fc
4 00000000 00000020 0 00000002

// File: src.f
logic/dcache_pkg.sv
logic/dcache_ctrl.sv
logic/tag_store.sv
logic/line_store.sv
logic/bus_master.sv
logic/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_dcache
FILELIST = src.f

SRCS = $(wildcard logic/*.sv tests/*.sv)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
